// ==== source/muldiv_isa_pkg.sv ====
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32M words and operation codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package muldiv_isa_pkg;

    // one register-file word, also used for quotient and remainder
    typedef logic [31:0] word_t;

    // full product of two words; the divider keeps its shifted divisor here too
    typedef logic [63:0] dword_t;

    // funct3 field of the OP opcode when funct7 selects the M extension
    typedef enum logic [2:0]
    {
        OP_MUL    = 3'd0,   // low word, sign does not matter
        OP_MULH   = 3'd1,   // high word, signed x signed
        OP_MULHSU = 3'd2,   // high word, signed x unsigned
        OP_MULHU  = 3'd3,   // high word, unsigned x unsigned
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

endpackage

`default_nettype wire

// ==== source/muldiv_ctrl_pkg.sv ====
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package muldiv_ctrl_pkg;

    // one operation walks IDLE -> LOAD -> STEP x32 -> FIX -> IDLE
    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,     // magnitudes into the datapath
        ST_STEP = 2'd2,     // one bit per cycle
        ST_FIX  = 2'd3      // sign applied to the finished value
    } seq_state_e;

    // counts the 32 iteration cycles, wraps at the last one
    typedef logic [4:0] step_cnt_t;

    // rising edges from the accepting edge of a start to the edge raising done
    // 1 load + 32 steps + 1 fix + 1 output register
    localparam int MULDIV_LATENCY = 35;

endpackage

`default_nettype wire

// ==== source/muldiv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_decode
    import muldiv_isa_pkg::*;
    import muldiv_ctrl_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_start,
    input  wire muldiv_op_e i_funct3,
    input  wire word_t      i_op1,
    input  wire word_t      i_op2,
    output logic            o_busy,
    output logic            o_load,
    output logic            o_step,
    output logic            o_fix,
    output logic            o_finish,
    output logic            o_is_div,
    output logic            o_op1_signed,
    output logic            o_op2_signed,
    output logic            o_rem_op,
    output muldiv_op_e      o_op,
    output word_t           o_op1,
    output word_t           o_op2
);

    seq_state_e state;
    step_cnt_t  step_cnt;
    logic       drain;      // cycle after FIX while the result stage registers
    logic       accept;

    // a start only counts when nothing is in flight
    assign accept = i_start && !o_busy;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state    <= ST_IDLE;
            step_cnt <= '0;
            drain    <= 1'b0;
        end
        else
        begin
            drain <= (state == ST_FIX);
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                        state <= ST_LOAD;
                end
                ST_LOAD:
                begin
                    state    <= ST_STEP;
                    step_cnt <= '0;
                end
                ST_STEP:
                begin
                    step_cnt <= step_cnt + 1'b1;
                    if (&step_cnt)          // 32nd iteration done
                        state <= ST_FIX;
                end
                default:
                    state <= ST_IDLE;       // ST_FIX lasts one cycle
            endcase
        end
    end

    // operation and operands stay put until the next accepted start
    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            o_op  <= i_funct3;
            o_op1 <= i_op1;
            o_op2 <= i_op2;
        end
    end

    assign o_busy   = (state != ST_IDLE) || drain;
    assign o_load   = (state == ST_LOAD);
    assign o_step   = (state == ST_STEP);
    assign o_fix    = (state == ST_FIX);
    assign o_finish = (state == ST_FIX);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // signedness of the latched operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        o_op1_signed = 1'b0;
        o_op2_signed = 1'b0;
        case (o_op)
            OP_MULH, OP_DIV, OP_REM:
            begin
                o_op1_signed = 1'b1;
                o_op2_signed = 1'b1;
            end
            OP_MULHSU:
                o_op1_signed = 1'b1;        // rs2 is taken as unsigned
            default:
                ;   // MUL gives the same low word either way
        endcase
    end

    assign o_is_div = o_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign o_rem_op = o_op inside {OP_REM, OP_REMU};

endmodule

`default_nettype wire

// ==== source/muldiv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_execute
    import muldiv_isa_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_load,
    input  wire         i_step,
    input  wire         i_fix,
    input  wire         i_is_div,
    input  wire         i_op1_signed,
    input  wire         i_op2_signed,
    input  wire         i_rem_op,
    input  wire word_t  i_op1,
    input  wire word_t  i_op2,
    output dword_t      o_product,
    output word_t       o_quotient,
    output word_t       o_remainder
);

    word_t  op1_mag;
    word_t  op2_mag;
    logic   op1_neg;
    logic   op2_neg;
    logic   mul_sign;
    logic   div_sign;
    logic   out_sign;       // negate the finished value in the fix cycle

    // multiplier state
    word_t       mcand;
    dword_t      product;
    logic [32:0] partial;   // upper half plus multiplicand, with carry

    // divider state
    word_t  remainder;
    dword_t divisor;        // bit 63 stays zero, 63 useful bits
    word_t  quotient;
    word_t  quot_mask;
    word_t  diff;
    logic   fits;

    assign op1_neg = i_op1_signed && i_op1[31];
    assign op2_neg = i_op2_signed && i_op2[31];

    // the most negative value maps onto itself, which reads correctly as unsigned
    assign op1_mag = op1_neg ? -i_op1 : i_op1;
    assign op2_mag = op2_neg ? -i_op2 : i_op2;

    assign mul_sign = op1_neg ^ op2_neg;

    // a zero divisor keeps the all-ones quotient unsigned
    // a remainder always follows the dividend
    assign div_sign = i_rem_op ? op1_neg : ((op1_neg ^ op2_neg) && (|i_op2));

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            out_sign <= 1'b0;
        else if (i_load)
            out_sign <= i_is_div ? div_sign : mul_sign;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shift-add multiply step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // multiplier sits in the low half and is shifted out one bit per step
    assign partial = {1'b0, product[63:32]} + {1'b0, (product[0] ? mcand : '0)};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // restoring divide step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign fits = (divisor <= {32'b0, remainder});
    assign diff = remainder - divisor[31:0];   // upper divisor bits are zero whenever it fits

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            mcand     <= op1_mag;
            product   <= {32'b0, op2_mag};
            remainder <= op1_mag;
            divisor   <= {1'b0, op2_mag, 31'b0};
            quotient  <= '0;
            quot_mask <= 32'h8000_0000;
        end
        else if (i_step)
        begin
            if (i_is_div)
            begin
                if (fits)
                begin
                    remainder <= diff;
                    quotient  <= quotient | quot_mask;
                end
                divisor   <= divisor >> 1;
                quot_mask <= quot_mask >> 1;
            end
            else
            begin
                product <= {partial, product[31:1]};
            end
        end
        else if (i_fix && out_sign)
        begin
            if (!i_is_div)
                product <= -product;
            else if (i_rem_op)
                remainder <= -remainder;
            else
                quotient <= -quotient;
        end
    end

    assign o_product   = product;
    assign o_quotient  = quotient;
    assign o_remainder = remainder;

endmodule

`default_nettype wire

// ==== source/muldiv_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_result
    import muldiv_isa_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_finish,
    input  wire muldiv_op_e i_op,
    input  wire dword_t     i_product,
    input  wire word_t      i_quotient,
    input  wire word_t      i_remainder,
    output word_t           o_result,
    output logic            o_done
);

    logic  finish_q;    // execute has applied the sign by now
    word_t selected;

    always_comb
    begin
        case (i_op)
            OP_MUL:
                selected = i_product[31:0];
            OP_MULH, OP_MULHSU, OP_MULHU:
                selected = i_product[63:32];
            OP_DIV, OP_DIVU:
                selected = i_quotient;
            default:
                selected = i_remainder;     // REM and REMU
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            finish_q <= 1'b0;
            o_done   <= 1'b0;
            o_result <= '0;
        end
        else
        begin
            finish_q <= i_finish;
            o_done   <= finish_q;       // single-cycle pulse
            if (finish_q)
                o_result <= selected;   // held until the next operation completes
        end
    end

endmodule

`default_nettype wire

// ==== source/muldiv_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_top
    import muldiv_isa_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_start,
    input  wire muldiv_op_e i_funct3,
    input  wire word_t      i_op1,
    input  wire word_t      i_op2,
    output word_t           o_result,
    output logic            o_done,
    output logic            o_busy
);

    logic       load;
    logic       step;
    logic       fix;
    logic       finish;
    logic       is_div;
    logic       op1_signed;
    logic       op2_signed;
    logic       rem_op;
    muldiv_op_e op;
    word_t      op1;
    word_t      op2;
    dword_t     product;
    word_t      quotient;
    word_t      remainder;

    muldiv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_funct3       (i_funct3),
        .i_op1          (i_op1),
        .i_op2          (i_op2),
        .o_busy         (o_busy),
        .o_load         (load),
        .o_step         (step),
        .o_fix          (fix),
        .o_finish       (finish),
        .o_is_div       (is_div),
        .o_op1_signed   (op1_signed),
        .o_op2_signed   (op2_signed),
        .o_rem_op       (rem_op),
        .o_op           (op),
        .o_op1          (op1),
        .o_op2          (op2)
    );

    muldiv_execute u_execute
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_load         (load),
        .i_step         (step),
        .i_fix          (fix),
        .i_is_div       (is_div),
        .i_op1_signed   (op1_signed),
        .i_op2_signed   (op2_signed),
        .i_rem_op       (rem_op),
        .i_op1          (op1),
        .i_op2          (op2),
        .o_product      (product),
        .o_quotient     (quotient),
        .o_remainder    (remainder)
    );

    muldiv_result u_result
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_finish       (finish),
        .i_op           (op),
        .i_product      (product),
        .i_quotient     (quotient),
        .i_remainder    (remainder),
        .o_result       (o_result),
        .o_done         (o_done)
    );

endmodule

`default_nettype wire

// ==== testbench/muldiv_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_properties
    import muldiv_ctrl_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_start,
    input  wire             i_busy,
    input  wire             i_done,
    input  wire seq_state_e i_state
);

    logic accepted;

    assign accepted = i_start && !i_busy;   // same acceptance rule as decode

    busy_done_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_busy && i_done))
        else $error("o_busy and o_done are high in the same cycle");

    done_single_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |=> !i_done)
        else $error("o_done stayed high for more than one cycle");

    // done is registered at the latency edge and shows up in the sample one edge later
    done_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        accepted |=> (!i_done) [*MULDIV_LATENCY] ##1 i_done)
        else $error("o_done did not follow the accepted start by the fixed latency");

    idle_needs_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ST_IDLE) && !accepted |=> (i_state == ST_IDLE))
        else $error("sequencer left ST_IDLE without an accepted start");

endmodule

bind muldiv_top muldiv_properties u_properties
(
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (i_start),
    .i_busy     (o_busy),
    .i_done     (o_done),
    .i_state    (u_decode.state)
);

`default_nettype wire

// ==== testbench/muldiv_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb
    import muldiv_isa_pkg::*;
    import muldiv_ctrl_pkg::*;
();

    localparam int NUM_DIRECTED = 8;
    localparam int NUM_RANDOM   = 400;
    localparam int CYCLE_LIMIT  = (NUM_DIRECTED + NUM_RANDOM) * 40 + 200;

    logic       clk;
    logic       rst_n;
    logic       start;
    muldiv_op_e funct3;
    word_t      op1;
    word_t      op2;
    word_t      result;
    logic       done;
    logic       busy;

    logic [31:0] rng_state;
    word_t       last_result;       // value o_result has to hold between completions
    int          mismatch_count;
    int          failure_count;
    int          cycle_count = 0;

    muldiv_top UUT
    (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_funct3   (funct3),
        .i_op1      (op1),
        .i_op2      (op2),
        .o_result   (result),
        .o_done     (done),
        .o_busy     (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // watchdog for a DUT that never raises o_done
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: no end of test after %0d cycles", cycle_count);
            $display("errors: %0d mismatches, %0d other failures",
                     mismatch_count, failure_count + 1);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // roughly one operand in eight is a corner value
    function automatic word_t pick_operand();
        logic [31:0] r;
        word_t       value;
        r = xorshift32();
        value = xorshift32();
        if (r[2:0] == 3'd0)
        begin
            case (r[4:3])
                2'd0:    value = 32'h0000_0000;
                2'd1:    value = 32'hffff_ffff;
                default: value = 32'h8000_0000;
            endcase
        end
        return value;
    endfunction

    function automatic word_t model_result(muldiv_op_e op, word_t a, word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic signed [63:0] p_ss;
        logic signed [63:0] p_su;
        logic signed [63:0] p_uu;
        logic signed [63:0] q_s;
        logic signed [63:0] r_s;
        logic signed [63:0] q_u;
        logic signed [63:0] r_u;
        word_t              value;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        p_ss = sa * sb;
        p_su = sa * ub;
        p_uu = ua * ub;
        q_s = -64'sd1;      // a zero divisor sets every quotient bit
        q_u = -64'sd1;
        r_s = sa;           // and leaves the dividend as remainder
        r_u = ua;
        if (b != 32'd0)
        begin
            q_u = ua / ub;
            r_u = ua % ub;
            if (a == 32'h8000_0000 && b == 32'hffff_ffff)
            begin
                q_s = sa;   // signed overflow returns the dividend
                r_s = 64'sd0;
            end
            else
            begin
                q_s = sa / sb;
                r_s = sa % sb;
            end
        end
        case (op)
            OP_MUL:    value = p_ss[31:0];
            OP_MULH:   value = p_ss[63:32];
            OP_MULHSU: value = p_su[63:32];
            OP_MULHU:  value = p_uu[63:32];
            OP_DIV:    value = q_s[31:0];
            OP_DIVU:   value = q_u[31:0];
            OP_REM:    value = r_s[31:0];
            default:   value = r_u[31:0];
        endcase
        return value;
    endfunction

    task automatic check_idle();
        assert (busy === 1'b0)
        else
        begin
            $display("Mismatch at %0t: o_busy got %b expected 0", $time, busy);
            mismatch_count++;
        end
        assert (done === 1'b0)
        else
        begin
            $display("Mismatch at %0t: o_done got %b expected 0", $time, done);
            mismatch_count++;
        end
        assert (result === 32'h0)
        else
        begin
            $display("Mismatch at %0t: o_result got %h expected 00000000", $time, result);
            mismatch_count++;
        end
    endtask

    // one operation, with an optional ignored start while busy
    task automatic run_op(input muldiv_op_e op, input word_t a, input word_t b,
                          input int stray_at);
        word_t       expected;
        logic [31:0] r;
        int          edges;
        logic        seen;
        expected = model_result(op, a, b);
        @(posedge clk);
        start  <= 1'b1;
        funct3 <= op;
        op1    <= a;
        op2    <= b;
        @(posedge clk);                 // accepting edge
        start <= 1'b0;
        edges = 0;
        seen  = 1'b0;
        while (!seen)
        begin
            @(posedge clk);
            edges++;
            if (edges == stray_at)
            begin
                r = xorshift32();
                start  <= 1'b1;
                funct3 <= muldiv_op_e'(r[2:0]);
                op1    <= xorshift32();
                op2    <= xorshift32();
            end
            else if (edges == stray_at + 1)
                start <= 1'b0;
            @(negedge clk);             // outputs settled mid-cycle
            seen = done;
            assert (busy === (edges < MULDIV_LATENCY))
            else
            begin
                $display("Mismatch at %0t: o_busy got %b expected %b", $time, busy,
                         edges < MULDIV_LATENCY);
                mismatch_count++;
            end
            if (!seen)
            begin
                assert (result === last_result)
                else
                begin
                    $display("Mismatch at %0t: o_result got %h expected %h", $time,
                             result, last_result);
                    mismatch_count++;
                end
            end
        end
        assert (edges == MULDIV_LATENCY)
        else
        begin
            $display("o_done came %0d edges after the start instead of %0d", edges,
                     MULDIV_LATENCY);
            failure_count++;
        end
        assert (result === expected)
        else
        begin
            $display("Mismatch at %0t: o_result got %h expected %h (%s %h, %h)", $time,
                     result, expected, op.name(), a, b);
            mismatch_count++;
        end
        last_result = expected;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        logic [31:0] r;
        word_t       a;
        word_t       b;
        int          stray;
        rng_state      = 32'h06b2_b313;
        mismatch_count = 0;
        failure_count  = 0;
        last_result    = '0;
        rst_n  = 1'b0;
        start  = 1'b0;
        funct3 = OP_MUL;
        op1    = '0;
        op2    = '0;

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_idle();                   // still in reset
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            check_idle();
        end

        // ISA corner cases first
        run_op(OP_DIV,    32'h1234_5678, 32'h0000_0000, 4);
        run_op(OP_DIVU,   32'h8765_4321, 32'h0000_0000, 0);
        run_op(OP_REM,    32'hf000_0001, 32'h0000_0000, 34);
        run_op(OP_REMU,   32'hdead_beef, 32'h0000_0000, 0);
        run_op(OP_DIV,    32'h8000_0000, 32'hffff_ffff, 0);
        run_op(OP_REM,    32'h8000_0000, 32'hffff_ffff, 4);
        run_op(OP_MULH,   32'h8000_0000, 32'h8000_0000, 0);
        run_op(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 34);

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            r = xorshift32();
            a = pick_operand();
            b = pick_operand();
            case (i % 4)
                0:       stray = 4;
                1:       stray = 34;        // lands on the last busy edge
                default: stray = 0;
            endcase
            run_op(muldiv_op_e'(r[2:0]), a, b, stray);
        end

        repeat (4) @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/muldiv_isa_pkg.sv
source/muldiv_ctrl_pkg.sv
source/muldiv_decode.sv
source/muldiv_execute.sv
source/muldiv_result.sv
source/muldiv_top.sv
testbench/muldiv_properties.sv
testbench/muldiv_tb.sv

// ==== Bender.yml ====
package:
  name: muldiv

sources:
  # packages first, then the datapath and its top level
  - source/muldiv_isa_pkg.sv
  - source/muldiv_ctrl_pkg.sv
  - source/muldiv_decode.sv
  - source/muldiv_execute.sv
  - source/muldiv_result.sv
  - source/muldiv_top.sv

  - target: test
    files:
      - testbench/muldiv_properties.sv
      - testbench/muldiv_tb.sv
